/* hw/pipeStagePkg.sv */
`default_nettype none

package pipeStagePkg;

    // stage registers after fetch
    localparam int numStages = 7;

    // bit position of each stage in the control vectors
    localparam int stF2 = 0;
    localparam int stD  = 1;
    localparam int stI  = 2;
    localparam int stE  = 3;
    localparam int stM  = 4;
    localparam int stM2 = 5;
    localparam int stW  = 6;

    // one bit per stage, used for stall and flush
    typedef logic [numStages-1:0] stageVec_t;

endpackage

`default_nettype wire

/* hw/fetchPkg.sv */
`default_nettype none

package fetchPkg;

    // byte address width of the program counter
    localparam int pcWidth = 32;

    typedef logic [pcWidth-1:0] pc_t;

endpackage

`default_nettype wire

/* hw/fetchUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchUnit
    import fetchPkg::*;
#(
    parameter pc_t resetPc   = 32'h0000_1000,
    parameter pc_t excVector = 32'h0000_0100,
    parameter pc_t pcStep    = 32'd4
) (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic stallF,
    input  wire logic excRedirect,
    input  wire logic jrRedirect,
    input  wire pc_t  jrTarget,
    output pc_t       fetchPc
);

    logic pendValid;
    pc_t  pendTarget;
    pc_t  redirectTarget;

    // exception target wins, the hazard unit never raises both
    assign redirectTarget = excRedirect ? excVector : jrTarget;

    always_ff @(posedge clk) begin
        if (reset) begin
            fetchPc   <= resetPc;
            pendValid <= 1'b0;
        end else if (excRedirect || jrRedirect) begin
            if (stallF) begin
                // icache busy, remember where to go
                pendValid <= 1'b1;
            end else begin
                fetchPc   <= redirectTarget;
                pendValid <= 1'b0;
            end
        end else if (!stallF) begin
            if (pendValid) begin
                fetchPc   <= pendTarget;
                pendValid <= 1'b0;
            end else begin
                fetchPc <= fetchPc + pcStep;
            end
        end
    end

    // payload only, qualified by pendValid
    always_ff @(posedge clk) begin
        if ((excRedirect || jrRedirect) && stallF) begin
            pendTarget <= redirectTarget;
        end
    end

    // a remembered redirect must be consumed before another one shows up
    assert property (@(posedge clk) disable iff (reset)
        !(pendValid && !stallF && (excRedirect || jrRedirect)))
        else $error("fetchUnit: redirect collides with a pending redirect");

endmodule

`default_nettype wire

/* hw/pipeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeStage
    import fetchPkg::*;
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic stall,
    input  wire logic flush,
    input  wire logic prevStall,
    input  wire logic inValid,
    input  wire pc_t  inPc,
    output logic      outValid,
    output pc_t       outPc
);

    // flush beats stall, a stalled predecessor sends a bubble
    always_ff @(posedge clk) begin
        if (reset) begin
            outValid <= 1'b0;
        end else if (flush) begin
            outValid <= 1'b0;
        end else if (!stall) begin
            outValid <= prevStall ? 1'b0 : inValid;
        end
    end

    // pc rides along without reset, valid bit qualifies it
    always_ff @(posedge clk) begin
        if (!stall && !prevStall) begin
            outPc <= inPc;
        end
    end

    // hazard rules keep these exclusive per stage
    assert property (@(posedge clk) disable iff (reset) !(stall && flush))
        else $error("pipeStage: stall and flush both high");

endmodule

`default_nettype wire

/* hw/hazardUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazardUnit
    import pipeStagePkg::*;
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic iWait,
    input  wire logic dWait,
    input  wire logic eWait,
    input  wire logic overflowI,
    input  wire logic jrI,
    input  wire logic excpM,
    input  wire logic excpW,
    output logic      stallF,
    output stageVec_t stall,
    output stageVec_t flush,
    output logic      excRedirect,
    output logic      jrRedirect
);

    // redirects that met an icache wait
    logic excIwait;
    logic jrIwait;
    logic excIwaitNext;
    logic jrIwaitNext;

    always_ff @(posedge clk) begin
        if (reset) begin
            excIwait <= 1'b0;
            jrIwait  <= 1'b0;
        end else begin
            excIwait <= excIwaitNext;
            jrIwait  <= jrIwaitNext;
        end
    end

    always_comb begin
        stallF       = 1'b0;
        stall        = '0;
        flush        = '0;
        excRedirect  = 1'b0;
        jrRedirect   = 1'b0;
        excIwaitNext = excIwait;
        jrIwaitNext  = jrIwait;

        if (excpM || excpW) begin
            // kill everything younger than the faulting instruction
            flush[stF2] = 1'b1;
            flush[stD]  = 1'b1;
            flush[stI]  = 1'b1;
            flush[stE]  = 1'b1;
            flush[stM]  = 1'b1;
            if (excpW) begin
                flush[stM2] = 1'b1;
                flush[stW]  = 1'b1;
            end
            excRedirect = 1'b1;
            if (iWait) begin
                stallF       = 1'b1;
                excIwaitNext = 1'b1;
            end
        end else if (dWait) begin
            // freeze fetch through M2 while W drains
            stallF      = 1'b1;
            stall[stF2] = 1'b1;
            stall[stD]  = 1'b1;
            stall[stI]  = 1'b1;
            stall[stE]  = 1'b1;
            stall[stM]  = 1'b1;
            stall[stM2] = 1'b1;
        end else if (eWait) begin
            // E holds and M gets a bubble
            stallF      = 1'b1;
            stall[stF2] = 1'b1;
            stall[stD]  = 1'b1;
            stall[stI]  = 1'b1;
            stall[stE]  = 1'b1;
            flush[stM]  = 1'b1;
        end else if (jrI) begin
            flush[stF2] = 1'b1;
            flush[stD]  = 1'b1;
            flush[stI]  = 1'b1;
            jrRedirect  = 1'b1;
            if (iWait) begin
                stallF      = 1'b1;
                jrIwaitNext = 1'b1;
            end
        end else if (overflowI) begin
            stallF      = 1'b1;
            stall[stF2] = 1'b1;
            stall[stD]  = 1'b1;
            stall[stI]  = 1'b1;
        end else if (iWait) begin
            // nothing valid comes out of the icache yet
            stallF      = 1'b1;
            flush[stF2] = 1'b1;
        end

        // drop what was fetched before the redirect landed
        if (!stallF && excIwait) begin
            flush[stF2]  = 1'b1;
            flush[stD]   = 1'b1;
            excIwaitNext = 1'b0;
        end
        if (!stallF && jrIwait) begin
            flush[stF2] = 1'b1;
            flush[stD]  = 1'b1;
            jrIwaitNext = 1'b0;
        end
    end

    // at most one redirect parked behind the icache
    assert property (@(posedge clk) disable iff (reset) !(excIwait && jrIwait))
        else $error("hazardUnit: two redirects parked behind the icache");

endmodule

`default_nettype wire

/* hw/retireUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module retireUnit
    import fetchPkg::*;
#(
    parameter int countWidth = 16
) (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        wValid,
    input  wire pc_t         wPc,
    output logic             retireValid,
    output pc_t              retirePc,
    output logic [countWidth-1:0] retireCount
);

    // one-cycle strobe per token leaving W
    always_ff @(posedge clk) begin
        if (reset) begin
            retireValid <= 1'b0;
        end else begin
            retireValid <= wValid;
        end
    end

    always_ff @(posedge clk) begin
        if (wValid) begin
            retirePc <= wPc;
        end
    end

    // counts the strobe and trails retireValid by one edge
    always_ff @(posedge clk) begin
        if (reset) begin
            retireCount <= '0;
        end else if (retireValid) begin
            retireCount <= retireCount + 1'b1;
        end
    end

    // a valid token in W always carries a known pc
    assert property (@(posedge clk) disable iff (reset) wValid |-> !$isunknown(wPc))
        else $error("retireUnit: W holds a valid token with an unknown pc");

endmodule

`default_nettype wire

/* hw/pipeCtrlTop.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeCtrlTop
    import pipeStagePkg::*;
    import fetchPkg::*;
#(
    parameter pc_t resetPc    = 32'h0000_1000,
    parameter pc_t excVector  = 32'h0000_0100,
    parameter pc_t pcStep     = 32'd4,
    parameter int  countWidth = 16
) (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic iWait,
    input  wire logic dWait,
    input  wire logic eWait,
    input  wire logic overflowI,
    input  wire logic jrI,
    input  wire pc_t  jrTarget,
    input  wire logic excpM,
    input  wire logic excpW,
    output logic      retireValid,
    output pc_t       retirePc,
    output logic [countWidth-1:0] retireCount
);

    logic      stallF;
    stageVec_t stall;
    stageVec_t flush;
    logic      excRedirect;
    logic      jrRedirect;

    // index 0 is the fetch token, index k+1 is the output of stage k
    logic [numStages:0] chainValid;
    pc_t                chainPc [numStages+1];
    // stall seen by each stage's predecessor
    logic [numStages-1:0] prevStall;

    // fetch always hands out a valid token
    assign chainValid[0] = 1'b1;
    assign prevStall     = {stall[numStages-2:0], stallF};

    fetchUnit #(
        .resetPc  (resetPc),
        .excVector(excVector),
        .pcStep   (pcStep)
    ) fetchUnit_i (
        .clk        (clk),
        .reset      (reset),
        .stallF     (stallF),
        .excRedirect(excRedirect),
        .jrRedirect (jrRedirect),
        .jrTarget   (jrTarget),
        .fetchPc    (chainPc[0])
    );

    hazardUnit hazardUnit_i (
        .clk        (clk),
        .reset      (reset),
        .iWait      (iWait),
        .dWait      (dWait),
        .eWait      (eWait),
        .overflowI  (overflowI),
        .jrI        (jrI),
        .excpM      (excpM),
        .excpW      (excpW),
        .stallF     (stallF),
        .stall      (stall),
        .flush      (flush),
        .excRedirect(excRedirect),
        .jrRedirect (jrRedirect)
    );

    // F2, D, I, E, M, M2, W
    for (genvar k = 0; k < numStages; k++) begin : gStage
        pipeStage pipeStage_i (
            .clk      (clk),
            .reset    (reset),
            .stall    (stall[k]),
            .flush    (flush[k]),
            .prevStall(prevStall[k]),
            .inValid  (chainValid[k]),
            .inPc     (chainPc[k]),
            .outValid (chainValid[k+1]),
            .outPc    (chainPc[k+1])
        );
    end

    retireUnit #(
        .countWidth(countWidth)
    ) retireUnit_i (
        .clk        (clk),
        .reset      (reset),
        .wValid     (chainValid[numStages]),
        .wPc        (chainPc[numStages]),
        .retireValid(retireValid),
        .retirePc   (retirePc),
        .retireCount(retireCount)
    );

endmodule

`default_nettype wire

/* test/pipeCtrlChecker.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeCtrlChecker
    import pipeStagePkg::*;
    import fetchPkg::*;
#(
    parameter pc_t resetPc    = 32'h0000_1000,
    parameter pc_t excVector  = 32'h0000_0100,
    parameter pc_t pcStep     = 32'd4,
    parameter int  countWidth = 16
) (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic iWait,
    input  wire logic dWait,
    input  wire logic eWait,
    input  wire logic overflowI,
    input  wire logic jrI,
    input  wire pc_t  jrTarget,
    input  wire logic excpM,
    input  wire logic excpW,
    input  wire logic [3:0] phase,
    input  wire logic retireValid,
    input  wire pc_t  retirePc,
    input  wire logic [countWidth-1:0] retireCount,
    output int        errorCount,
    output int        checkCount
);

    // reference state, stepped once per rising edge
    pc_t                   mPc;
    logic                  mPendValid;
    pc_t                   mPendTarget;
    logic                  mExcIwait;
    logic                  mJrIwait;
    logic [numStages-1:0]  mValid;
    pc_t                   mStagePc [numStages];
    logic                  expValid;
    pc_t                   expPc;
    logic [countWidth-1:0] expCount;
    logic                  armed;
    logic                  firstSeen;
    int                    edgesSinceReset;
    logic [3:0]            curPhase;

    function automatic string phaseName(input logic [3:0] p);
        case (p)
            4'd1: return "quiet flow";
            4'd2: return "data and execute waits";
            4'd3: return "jump redirect";
            4'd4: return "exceptions";
            4'd5: return "redirect during icache wait";
            4'd6: return "random mix";
            4'd7: return "final drain";
            default: return "reset";
        endcase
    endfunction

    function automatic void resetModel();
        mPc        = resetPc;
        mPendValid = 1'b0;
        mExcIwait  = 1'b0;
        mJrIwait   = 1'b0;
        mValid     = '0;
        expValid   = 1'b0;
        expCount   = '0;
    endfunction

    // next state of fetch, stages, pending flags and retire
    function automatic void stepModel(input logic iw, dw, ew, ov, jr, exM, exW,
                                      input pc_t jt);
        logic                 sF;
        stageVec_t            st;
        stageVec_t            fl;
        logic                 redirect;
        logic                 nExc;
        logic                 nJr;
        pc_t                  target;
        pc_t                  inP;
        logic [numStages-1:0] prevSt;
        logic [numStages-1:0] inV;
        logic [numStages-1:0] nValid;
        pc_t                  nPc [numStages];
        sF       = 1'b0;
        st       = '0;
        fl       = '0;
        redirect = 1'b0;
        target   = jt;
        nExc     = mExcIwait;
        nJr      = mJrIwait;
        if (exM || exW) begin
            fl[stM:stF2] = '1;
            if (exW) begin
                fl[stW:stM2] = '1;
            end
            redirect = 1'b1;
            target   = excVector;
            sF       = iw;
            nExc     = nExc | iw;
        end else if (dw) begin
            sF            = 1'b1;
            st[stM2:stF2] = '1;
        end else if (ew) begin
            sF           = 1'b1;
            st[stE:stF2] = '1;
            fl[stM]      = 1'b1;
        end else if (jr) begin
            fl[stI:stF2] = '1;
            redirect     = 1'b1;
            sF           = iw;
            nJr          = nJr | iw;
        end else if (ov) begin
            sF           = 1'b1;
            st[stI:stF2] = '1;
        end else if (iw) begin
            sF       = 1'b1;
            fl[stF2] = 1'b1;
        end
        // wrong-path fetches die once the icache lets go
        if (!sF && (mExcIwait || mJrIwait)) begin
            fl[stD:stF2] = '1;
            nExc         = 1'b0;
            nJr          = 1'b0;
        end
        prevSt = {st[numStages-2:0], sF};
        inV    = {mValid[numStages-2:0], 1'b1};
        nValid = mValid;
        nPc    = mStagePc;
        for (int k = 0; k < numStages; k++) begin
            if (k == 0) begin
                inP = mPc;
            end else begin
                inP = mStagePc[k-1];
            end
            if (fl[k] || (!st[k] && prevSt[k])) begin
                nValid[k] = 1'b0;
            end else if (!st[k]) begin
                nValid[k] = inV[k];
                nPc[k]    = inP;
            end
        end
        if (expValid) begin
            expCount = expCount + countWidth'(1);
        end
        expValid = mValid[numStages-1];
        if (mValid[numStages-1]) begin
            expPc = mStagePc[numStages-1];
        end
        if (redirect && sF) begin
            mPendValid  = 1'b1;
            mPendTarget = target;
        end else if (redirect) begin
            mPc        = target;
            mPendValid = 1'b0;
        end else if (!sF && mPendValid) begin
            mPc        = mPendTarget;
            mPendValid = 1'b0;
        end else if (!sF) begin
            mPc = mPc + pcStep;
        end
        mValid    = nValid;
        mStagePc  = nPc;
        mExcIwait = nExc;
        mJrIwait  = nJr;
    endfunction

    task automatic compareValue(input string what, input logic [31:0] expVal,
                                input logic [31:0] actVal);
        checkCount++;
        if (expVal !== actVal) begin
            errorCount++;
            $display("[ERROR] %s: %s expected %h, actual %h",
                     phaseName(curPhase), what, expVal, actVal);
        end
    endtask

    initial begin
        armed      = 1'b0;
        firstSeen  = 1'b0;
        errorCount = 0;
        checkCount = 0;
    end

    always @(posedge clk) begin
        curPhase = phase;
        if (reset) begin
            resetModel();
            armed           = 1'b1;
            edgesSinceReset = 0;
        end else begin
            stepModel(iWait, dWait, eWait, overflowI, jrI, excpM, excpW, jrTarget);
            edgesSinceReset++;
        end
    end

    // outputs settle after the rising edge, compare half a cycle later
    always @(negedge clk) begin
        if (edgesSinceReset == 0) begin
            firstSeen = 1'b0;
        end
        if (armed) begin
            compareValue("retireValid", 32'(expValid), 32'(retireValid));
            compareValue("retireCount", 32'(expCount), 32'(retireCount));
            if (expValid) begin
                compareValue("retirePc", expPc, retirePc);
            end
            // latency from reset release, counted without the model
            if (!firstSeen && retireValid) begin
                firstSeen = 1'b1;
                compareValue("first retire edge", 32'd8, 32'(edgesSinceReset));
                compareValue("first retirePc", resetPc, retirePc);
            end
        end
    end

endmodule

`default_nettype wire

/* test/pipeCtrlTb.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeCtrlTb
    import fetchPkg::*;
();

    localparam pc_t resetPc    = 32'h0000_2000;
    localparam pc_t excVector  = 32'h0000_0180;
    localparam pc_t pcStep     = 32'd4;
    localparam int  countWidth = 16;

    // event mask bits for the environment events
    localparam logic [6:0] evI        = 7'b000_0001;
    localparam logic [6:0] evD        = 7'b000_0010;
    localparam logic [6:0] evE        = 7'b000_0100;
    localparam logic [6:0] evOv       = 7'b000_1000;
    localparam logic [6:0] evJr       = 7'b001_0000;
    localparam logic [6:0] evExM      = 7'b010_0000;
    localparam logic [6:0] evExW      = 7'b100_0000;
    localparam logic [6:0] evRedirect = evJr | evExM | evExW;
    localparam logic [6:0] evStall    = evI | evD | evE | evOv;

    logic                  clk;
    logic                  reset;
    logic                  iWait;
    logic                  dWait;
    logic                  eWait;
    logic                  overflowI;
    logic                  jrI;
    pc_t                   jrTarget;
    logic                  excpM;
    logic                  excpW;
    logic                  retireValid;
    pc_t                   retirePc;
    logic [countWidth-1:0] retireCount;
    logic [3:0]            phase;
    int                    errorCount;
    int                    checkCount;
    int                    timeouts;
    logic [6:0]            ev;
    pc_t                   jt;
    logic                  redirectHeld;

    pipeCtrlTop #(
        .resetPc   (resetPc),
        .excVector (excVector),
        .pcStep    (pcStep),
        .countWidth(countWidth)
    ) pipeCtrlTop_i (
        .clk        (clk),
        .reset      (reset),
        .iWait      (iWait),
        .dWait      (dWait),
        .eWait      (eWait),
        .overflowI  (overflowI),
        .jrI        (jrI),
        .jrTarget   (jrTarget),
        .excpM      (excpM),
        .excpW      (excpW),
        .retireValid(retireValid),
        .retirePc   (retirePc),
        .retireCount(retireCount)
    );

    pipeCtrlChecker #(
        .resetPc   (resetPc),
        .excVector (excVector),
        .pcStep    (pcStep),
        .countWidth(countWidth)
    ) checker_i (
        .clk        (clk),
        .reset      (reset),
        .iWait      (iWait),
        .dWait      (dWait),
        .eWait      (eWait),
        .overflowI  (overflowI),
        .jrI        (jrI),
        .jrTarget   (jrTarget),
        .excpM      (excpM),
        .excpW      (excpW),
        .phase      (phase),
        .retireValid(retireValid),
        .retirePc   (retirePc),
        .retireCount(retireCount),
        .errorCount (errorCount),
        .checkCount (checkCount)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // events hold for exactly one rising edge
    task automatic driveEvents(input logic [6:0] events, input pc_t target);
        @(negedge clk);
        iWait     = events[0];
        dWait     = events[1];
        eWait     = events[2];
        overflowI = events[3];
        jrI       = events[4];
        excpM     = events[5];
        excpW     = events[6];
        jrTarget  = target;
    endtask

    task automatic waitRetires(input int count, input int limit);
        int seen;
        int cycles;
        seen   = 0;
        cycles = 0;
        while (seen < count && cycles < limit) begin
            @(negedge clk);
            cycles++;
            if (retireValid) begin
                seen++;
            end
        end
        if (seen < count) begin
            timeouts++;
            $display("timeout: only %0d of %0d retires within %0d cycles in phase %0d",
                     seen, count, limit, phase);
        end
    endtask

    initial begin
        void'($urandom(4610));
        timeouts = 0;
        phase    = 4'd0;
        reset    = 1'b1;
        {iWait, dWait, eWait, overflowI, jrI, excpM, excpW} = '0;
        jrTarget = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        phase = 4'd1;
        waitRetires(20, 40);

        phase = 4'd2;
        repeat (3) driveEvents(evD, '0);
        driveEvents('0, '0);
        waitRetires(4, 20);
        repeat (2) driveEvents(evE, '0);
        driveEvents('0, '0);
        waitRetires(10, 30);

        phase = 4'd3;
        driveEvents(evJr, 32'h0000_4000);
        driveEvents('0, '0);
        waitRetires(10, 30);

        phase = 4'd4;
        driveEvents(evExM, '0);
        driveEvents('0, '0);
        waitRetires(10, 30);
        driveEvents(evExW, '0);
        driveEvents('0, '0);
        waitRetires(10, 30);

        phase = 4'd5;
        driveEvents(evJr | evI, 32'h0000_6000);
        repeat (3) driveEvents(evI, '0);
        driveEvents('0, '0);
        waitRetires(10, 40);
        driveEvents(evExM | evI, '0);
        repeat (2) driveEvents(evI, '0);
        driveEvents('0, '0);
        waitRetires(10, 40);

        phase = 4'd6;
        redirectHeld = 1'b0;
        for (int n = 0; n < 2000; n++) begin
            ev = '0;
            for (int b = 0; b < 7; b++) begin
                if ($urandom_range(99) < 4) begin
                    ev[b] = 1'b1;
                end
            end
            // a redirect parked behind an icache wait has to land first
            if (redirectHeld) begin
                ev = ev & ~evRedirect;
            end
            if ((ev & evRedirect) != '0 && ev[0]) begin
                redirectHeld = 1'b1;
            end else if ((ev & evStall) == '0) begin
                redirectHeld = 1'b0;
            end
            jt = $urandom() & 32'h000f_fffc;
            driveEvents(ev, jt);
        end

        phase = 4'd7;
        driveEvents('0, '0);
        waitRetires(10, 60);

        // last falling-edge compare is complete by the next rising edge
        @(posedge clk);
        $display("checks %0d, mismatches %0d, timeouts %0d", checkCount, errorCount, timeouts);
        if (errorCount == 0 && timeouts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
hw/pipeStagePkg.sv
hw/fetchPkg.sv
hw/fetchUnit.sv
hw/pipeStage.sv
hw/hazardUnit.sv
hw/retireUnit.sv
hw/pipeCtrlTop.sv
test/pipeCtrlChecker.sv
test/pipeCtrlTb.sv

/* Makefile */
TOP := pipeCtrlTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f filelist.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
